// File: flist.f
+incdir+include
hdl/mcu_bus_pkg.sv
hdl/uart_pkg.sv
hdl/uart_baud_timer.sv
hdl/uart_rx_fsm.sv
hdl/program_loader.sv
hdl/word_memory.sv
hdl/mcu_top.sv
verification/mcu_monitor.sv
verification/tb_mcu_top.sv

// File: hdl/mcu_bus_pkg.sv
`include "mcu_macros.svh"

package mcu_bus_pkg;

  // byte address on the memory bus
  typedef logic [`MCU_ADDR_WIDTH-1:0] mem_addr_t;

  // big-endian byte lanes of one memory word
  // hi lives at the even byte address, lo at the odd one
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } mem_bytes_t;

  // the same 16 bits seen as a whole word or as two byte lanes
  typedef union packed {
    logic [15:0] word;
    mem_bytes_t  bytes;
  } mem_word_u;

  // one memory access
  // with byt set only the lane picked by addr[0] is written
  typedef struct packed {
    mem_addr_t addr;
    logic      wr;
    logic      byt;
    mem_word_u wdata;
  } mem_req_t;

endpackage

// File: hdl/mcu_top.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module mcu_top (
  input  logic                  rst,
  input  logic                  clk,
  input  logic                  rx,
  input  mcu_bus_pkg::mem_req_t cpu_req,
  output logic [15:0]           rd_data,
  output logic                  load_done
);

  import mcu_bus_pkg::*;
  import uart_pkg::*;

  logic     restart;
  logic     mid_bit;
  rx_byte_t rx_byte;
  mem_req_t mem_req;

  uart_baud_timer #(
    .CLKS_PER_BIT (`MCU_CLKS_PER_BIT)
  ) uart_baud_timer_i (
    .rst     (rst),
    .clk     (clk),
    .restart (restart),
    .mid_bit (mid_bit)
  );

  uart_rx_fsm uart_rx_fsm_i (
    .rst     (rst),
    .clk     (clk),
    .rx      (rx),
    .mid_bit (mid_bit),
    .restart (restart),
    .rx_byte (rx_byte)
  );

  // owns the memory bus until the end marker, then hands it to the processor
  program_loader program_loader_i (
    .rst       (rst),
    .clk       (clk),
    .rx_byte   (rx_byte),
    .cpu_req   (cpu_req),
    .mem_req   (mem_req),
    .load_done (load_done)
  );

  word_memory #(
    .WORDS (`MCU_MEM_WORDS)
  ) word_memory_i (
    .rst     (rst),
    .clk     (clk),
    .mem_req (mem_req),
    .rd_data (rd_data)
  );

endmodule

// File: hdl/program_loader.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module program_loader (
  input  logic                  rst,
  input  logic                  clk,
  input  uart_pkg::rx_byte_t    rx_byte,
  input  mcu_bus_pkg::mem_req_t cpu_req,
  output mcu_bus_pkg::mem_req_t mem_req,
  output logic                  load_done
);

  import mcu_bus_pkg::*;

  logic                       phase_q;
  logic [15:0]                word_q;
  logic                       word_wr_q;
  logic [`MCU_ADDR_WIDTH-1:0] addr_q;
  logic                       load_done_q;
  logic                       reload_hit;
  mem_req_t                   load_req;

  // phase 0 waits for the high byte, phase 1 for the low byte
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      phase_q <= 1'b0;
    end else if (rx_byte.valid) begin
      phase_q <= ~phase_q;
    end
  end

  // the last two bytes, high byte first
  always_ff @(posedge rst) begin
    if (rx_byte.valid) begin
      word_q <= {word_q[7:0], rx_byte.data};
    end
  end

  // the word write follows the low-byte strobe by one cycle
  // once loading is done the memory is the processor's and no write is made
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      word_wr_q <= 1'b0;
    end else begin
      word_wr_q <= rx_byte.valid & phase_q & ~load_done_q;
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      addr_q <= `MCU_LOAD_BASE;
    end else if (load_done_q) begin
      addr_q <= `MCU_LOAD_BASE;
    end else if (word_wr_q) begin
      addr_q <= addr_q + `MCU_ADDR_WIDTH'd2;
    end
  end

  // a high byte outside 0x7c..0x7f can only be the start of a new program
  assign reload_hit = rx_byte.valid & ~phase_q &
                      (rx_byte.data[7:2] != `MCU_RELOAD_PREFIX);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      load_done_q <= 1'b0;
    end else if (word_wr_q && word_q == `MCU_END_MARKER) begin
      load_done_q <= 1'b1;
    end else if (reload_hit) begin
      load_done_q <= 1'b0;
    end
  end

  assign load_done = load_done_q;

  always_comb begin
    load_req.addr       = addr_q;
    load_req.wr         = word_wr_q;
    load_req.byt        = 1'b0;
    load_req.wdata.word = word_q;
  end

  assign mem_req = load_done_q ? cpu_req : load_req;

  // the marker raises load_done only after its own write has gone out
  a_no_load_write_when_done: assert property (
    @(posedge rst) disable iff (clk)
    word_wr_q |-> !load_done_q
  );

  // loader words are always whole, aligned words
  a_load_addr_even: assert property (
    @(posedge rst) disable iff (clk)
    word_wr_q |-> !mem_req.addr[0]
  );

endmodule

// File: hdl/uart_baud_timer.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module uart_baud_timer #(
  parameter int CLKS_PER_BIT = `MCU_CLKS_PER_BIT
) (
  input  logic rst,
  input  logic clk,
  input  logic restart,
  output logic mid_bit
);

  localparam int HALF_BIT = CLKS_PER_BIT / 2;
  localparam int CNT_W    = $clog2(CLKS_PER_BIT);

  logic [CNT_W-1:0] cnt_q;

  // down counter
  // while restart is held the count waits at half a bit, so the first
  // tick after release marks the middle of the start bit
  // every later tick is one full bit period on
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      cnt_q <= CNT_W'(HALF_BIT - 1);
    end else if (restart) begin
      cnt_q <= CNT_W'(HALF_BIT - 1);
    end else if (cnt_q == '0) begin
      cnt_q <= CNT_W'(CLKS_PER_BIT - 1);
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign mid_bit = (cnt_q == '0);

  // the receiver only holds restart while idle
  // a tick there would mean the frame ended off the bit grid
  a_no_tick_on_restart: assert property (
    @(posedge rst) disable iff (clk)
    !(restart && mid_bit)
  );

endmodule

// File: hdl/uart_pkg.sv
package uart_pkg;

  // receiver frame position
  // START waits for the start-bit middle, DATA collects eight bits,
  // STOP checks the framing bit
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } rx_state_t;

  // one received byte
  // valid is a single-cycle strobe and data is only meaningful with it
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
  } rx_byte_t;

endpackage

// File: hdl/uart_rx_fsm.sv
`timescale 1ns/1ps

module uart_rx_fsm (
  input  logic               rst,
  input  logic               clk,
  input  logic               rx,
  input  logic               mid_bit,
  output logic               restart,
  output uart_pkg::rx_byte_t rx_byte
);

  import uart_pkg::*;

  rx_state_t  state_q;
  logic       rx_meta_q;
  logic       rx_sync_q;
  logic       rx_prev_q;
  logic       rx_fall;
  logic [2:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic       valid_q;

  // two-flop synchronizer plus one more stage for edge detection
  // the line idles high, so that is the reset value
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  assign rx_fall = rx_prev_q & ~rx_sync_q;

  // the bit timer is held while idle and starts running from the start edge
  assign restart = (state_q == IDLE);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (rx_fall) begin
            state_q <= START;
          end
        end
        START: begin
          // a line that is high again at mid start bit was only a glitch
          if (mid_bit) begin
            if (rx_sync_q) begin
              state_q <= IDLE;
            end else begin
              state_q   <= DATA;
              bit_cnt_q <= '0;
            end
          end
        end
        DATA: begin
          if (mid_bit) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= STOP;
            end
          end
        end
        STOP: begin
          // a low stop bit is a framing error and the byte is dropped
          if (mid_bit) begin
            valid_q <= rx_sync_q;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // data arrives lsb first, so bits enter from the top
  always_ff @(posedge rst) begin
    if (state_q == DATA && mid_bit) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_byte = '{data: shift_q, valid: valid_q};

  // the loader toggles its byte phase on every strobe, a wide one would
  // shift the high/low pairing of every following word
  a_valid_one_cycle: assert property (
    @(posedge rst) disable iff (clk)
    rx_byte.valid |=> !rx_byte.valid
  );

endmodule

// File: hdl/word_memory.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module word_memory #(
  parameter int WORDS = `MCU_MEM_WORDS
) (
  input  logic                  rst,
  input  logic                  clk,
  input  mcu_bus_pkg::mem_req_t mem_req,
  output logic [15:0]           rd_data
);

  import mcu_bus_pkg::*;

  localparam int IDX_W = $clog2(WORDS);

  mem_word_u         mem_q [WORDS];
  logic [IDX_W-1:0]  idx;
  logic [15:0]       rd_q;

  // byte address to word index, addr[0] only picks the lane
  assign idx = mem_req.addr[IDX_W:1];

  always_ff @(posedge rst) begin
    if (mem_req.wr) begin
      if (mem_req.byt) begin
        // even address is the high byte, odd is the low byte
        if (!mem_req.addr[0]) begin
          mem_q[idx].bytes.hi <= mem_req.wdata.bytes.hi;
        end else begin
          mem_q[idx].bytes.lo <= mem_req.wdata.bytes.lo;
        end
      end else begin
        mem_q[idx].word <= mem_req.wdata.word;
      end
    end
  end

  // synchronous read, a write in the same cycle shows up one access later
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rd_q <= '0;
    end else begin
      rd_q <= mem_q[idx].word;
    end
  end

  assign rd_data = rd_q;

endmodule

// File: include/mcu_macros.svh
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// byte address width of the program memory
`define MCU_ADDR_WIDTH 12

// the first loaded word lands here, below it sits the processor's own area
`define MCU_LOAD_BASE 12'h300

// end-of-program word, written like any other word
`define MCU_END_MARKER 16'h7fff

// high bytes 0x7c..0x7f keep a finished load, anything else starts a reload
`define MCU_RELOAD_PREFIX 6'b01_1111

// serial timing
`define MCU_CLOCK_HZ 27_000_000
`define MCU_BAUD 115_200
`define MCU_CLKS_PER_BIT (`MCU_CLOCK_HZ / `MCU_BAUD)

// 4 KiB of byte addresses holds this many 16-bit words
`define MCU_MEM_WORDS 2048

`endif

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mcu_top -f flist.f

out=$(./obj_dir/Vtb_mcu_top)
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

// File: verification/mcu_monitor.sv
`timescale 1ns/1ps

module mcu_monitor (
  input  logic        rst,
  input  logic        clk,
  input  logic [15:0] rd_data,
  input  logic        load_done,
  input  logic        chk_rd,
  input  logic [15:0] exp_rd,
  input  logic        chk_done,
  input  logic        exp_done,
  output int          check_count,
  output int          error_count
);

  int checks = 0;
  int errors = 0;

  // a check request is raised on one rising edge and compared on the next,
  // when rd_data and load_done have settled from the previous edge
  always @(posedge rst) begin
    if (!clk) begin
      if (chk_rd) begin
        checks = checks + 1;
        if (rd_data !== exp_rd) begin
          errors = errors + 1;
          $display("mismatch at time %0t: rd_data expected %h got %h",
                   $time, exp_rd, rd_data);
        end
      end
      if (chk_done) begin
        checks = checks + 1;
        if (load_done !== exp_done) begin
          errors = errors + 1;
          $display("mismatch at time %0t: load_done expected %b got %b",
                   $time, exp_done, load_done);
        end
      end
    end
  end

  assign check_count = checks;
  assign error_count = errors;

endmodule

// File: verification/tb_mcu_top.sv
`timescale 1ns/1ps
`include "mcu_macros.svh"

module tb_mcu_top;

  import mcu_bus_pkg::*;

  localparam int BIT_CLKS   = `MCU_CLKS_PER_BIT;
  localparam int WAIT_LIMIT = 30 * `MCU_CLKS_PER_BIT;

  typedef enum logic [1:0] {
    OP_WORD,
    OP_BAD,
    OP_WR,
    OP_RD
  } op_t;

  // serial rows use data and exp_done, processor rows use the rest
  typedef struct packed {
    op_t         op;
    logic [15:0] data;
    mem_addr_t   addr;
    logic        byt;
    logic [15:0] exp_rd;
    logic        exp_done;
  } stim_row_t;

  logic        rst;
  logic        clk;
  logic        rx;
  mem_req_t    cpu_req;
  logic [15:0] rd_data;
  logic        load_done;
  logic        chk_rd;
  logic [15:0] exp_rd;
  logic        chk_done;
  logic        exp_done;
  int          check_count;
  int          error_count;
  int          timeout_count;
  stim_row_t   rows[$];

  mcu_top mcu_top_i (
    .rst       (rst),
    .clk       (clk),
    .rx        (rx),
    .cpu_req   (cpu_req),
    .rd_data   (rd_data),
    .load_done (load_done)
  );

  mcu_monitor mcu_monitor (
    .rst         (rst),
    .clk         (clk),
    .rd_data     (rd_data),
    .load_done   (load_done),
    .chk_rd      (chk_rd),
    .exp_rd      (exp_rd),
    .chk_done    (chk_done),
    .exp_done    (exp_done),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial rst = 1'b0;
  always #2 rst = ~rst;

  task automatic add_row(input op_t op, input logic [15:0] data, input mem_addr_t addr,
                         input logic byt, input logic [15:0] exp_rd_v, input logic exp_done_v);
    rows.push_back('{op, data, addr, byt, exp_rd_v, exp_done_v});
  endtask

  task automatic fill_table();
    // first program, with a processor write and a broken frame while loading
    add_row(OP_WORD, 16'h1234, 12'h000, 1'b0, 16'h0000, 1'b0);
    add_row(OP_WR,   16'hdead, 12'h300, 1'b0, 16'h0000, 1'b0);
    add_row(OP_BAD,  16'h005a, 12'h000, 1'b0, 16'h0000, 1'b0);
    add_row(OP_WORD, 16'ha5c3, 12'h000, 1'b0, 16'h0000, 1'b0);
    add_row(OP_WORD, 16'h0f0f, 12'h000, 1'b0, 16'h0000, 1'b0);
    add_row(OP_WORD, 16'h7c01, 12'h000, 1'b0, 16'h0000, 1'b0);
    add_row(OP_WORD, 16'h7fff, 12'h000, 1'b0, 16'h0000, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h300, 1'b0, 16'h1234, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h302, 1'b0, 16'ha5c3, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h304, 1'b0, 16'h0f0f, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h306, 1'b0, 16'h7c01, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h308, 1'b0, 16'h7fff, 1'b1);
    // processor word and byte-lane writes once the memory is handed over
    add_row(OP_WR,   16'hbeef, 12'h30a, 1'b0, 16'h0000, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h30a, 1'b0, 16'hbeef, 1'b1);
    add_row(OP_WR,   16'h12aa, 12'h30a, 1'b1, 16'h0000, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h30a, 1'b0, 16'h12ef, 1'b1);
    add_row(OP_WR,   16'hcc34, 12'h30b, 1'b1, 16'h0000, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h30a, 1'b0, 16'h1234, 1'b1);
    // a high byte of 0x7d keeps the finished load
    add_row(OP_WORD, 16'h7d55, 12'h000, 1'b0, 16'h0000, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h300, 1'b0, 16'h1234, 1'b1);
    // reload
    add_row(OP_WORD, 16'h1299, 12'h000, 1'b0, 16'h0000, 1'b0);
    add_row(OP_WORD, 16'h4321, 12'h000, 1'b0, 16'h0000, 1'b0);
    add_row(OP_WORD, 16'h7fff, 12'h000, 1'b0, 16'h0000, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h300, 1'b0, 16'h1299, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h302, 1'b0, 16'h4321, 1'b1);
    add_row(OP_RD,   16'h0000, 12'h304, 1'b0, 16'h7fff, 1'b1);
  endtask

  task automatic drive_bit(input logic b);
    rx <= b;
    repeat (BIT_CLKS) @(posedge rst);
  endtask

  // 8N1 frame, lsb first, followed by a random idle gap
  task automatic send_byte(input logic [7:0] data, input logic stop);
    int gap;
    gap = 4 + ($urandom % 32);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(stop);
    rx <= 1'b1;
    repeat (gap) @(posedge rst);
  endtask

  // load_done is read on falling edges, away from the DUT's updates
  task automatic wait_done(input logic level);
    int n;
    n = 0;
    @(negedge rst);
    while (load_done !== level && n < WAIT_LIMIT) begin
      @(negedge rst);
      n++;
    end
    if (load_done !== level) begin
      timeout_count++;
      $display("timeout at time %0t: load_done did not become %b within %0d cycles",
               $time, level, WAIT_LIMIT);
    end
    @(posedge rst);
  endtask

  task automatic check_done(input logic level);
    chk_done <= 1'b1;
    exp_done <= level;
    @(posedge rst);
    chk_done <= 1'b0;
  endtask

  task automatic cpu_write(input mem_addr_t addr, input logic [15:0] data, input logic byt);
    cpu_req.addr       <= addr;
    cpu_req.wr         <= 1'b1;
    cpu_req.byt        <= byt;
    cpu_req.wdata.word <= data;
    @(posedge rst);
    cpu_req.wr <= 1'b0;
  endtask

  // rd_data follows the address by one edge, the monitor compares one edge later
  task automatic cpu_read(input mem_addr_t addr, input logic [15:0] expected);
    cpu_req.addr <= addr;
    cpu_req.wr   <= 1'b0;
    @(posedge rst);
    chk_rd <= 1'b1;
    exp_rd <= expected;
    @(posedge rst);
    chk_rd <= 1'b0;
  endtask

  task automatic apply_row(input stim_row_t row);
    case (row.op)
      OP_WORD, OP_BAD: begin
        if (row.op == OP_WORD) begin
          send_byte(row.data[15:8], 1'b1);
          send_byte(row.data[7:0], 1'b1);
        end else begin
          send_byte(row.data[7:0], 1'b0);
        end
        wait_done(row.exp_done);
        check_done(row.exp_done);
      end
      OP_WR: cpu_write(row.addr, row.data, row.byt);
      default: cpu_read(row.addr, row.exp_rd);
    endcase
  endtask

  initial begin
    timeout_count = 0;
    clk      <= 1'b1;
    rx       <= 1'b1;
    cpu_req  <= '0;
    chk_rd   <= 1'b0;
    exp_rd   <= '0;
    chk_done <= 1'b0;
    exp_done <= 1'b0;
    void'($urandom(32'h6f07_ad21));
    fill_table();
    repeat (16) @(posedge rst);
    clk <= 1'b0;
    repeat (4) @(posedge rst);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    repeat (4) @(posedge rst);
    $display("checks %0d, mismatches %0d, timeouts %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
